// File: list.f
hw/dcache_pkg.sv
hw/cache_bus_pkg.sv
hw/dcache_array.sv
hw/dcache_ctrl.sv
hw/dcache.sv
tb/dcache_assertions.sv
tb/tb_dcache.sv

// File: Bender.yml
package:
  name: dcache

sources:
  # Packages first, geometry before bus types
  - hw/dcache_pkg.sv
  - hw/cache_bus_pkg.sv
  # RTL
  - hw/dcache_array.sv
  - hw/dcache_ctrl.sv
  - hw/dcache.sv
  # Testbench
  - target: test
    files:
      - tb/dcache_assertions.sv
      - tb/tb_dcache.sv

// File: tb/tb_dcache.sv
`timescale 1ns/10ps
`default_nettype none

module tb_dcache
	import dcache_pkg::*, cache_bus_pkg::*;
();

	localparam int CLK_PERIOD = 100;
	localparam int RESET_CYCLES = 5;
	localparam int DIRECTED_OPS = 6;
	localparam int NUM_OPS = 400;
	// Two write-back and two fill transfers at up to 4 cycles each plus margin
	localparam int OP_CYCLES = 40;
	// Every way dirty with two transfers each
	localparam int FLUSH_CYCLES = NUM_SETS * 2 * 2 * 5 + 20;
	localparam int TIMEOUT_CYCLES =
		RESET_CYCLES + (DIRECTED_OPS + NUM_OPS) * OP_CYCLES + FLUSH_CYCLES;
	// Few tags per set so dirty victims get evicted often
	localparam int NUM_TAGS = 6;

	logic CLK;
	logic nRST;
	dp_req_t dp_req;
	dp_rsp_t dp_rsp;
	mem_req_t mem_req;
	mem_rsp_t mem_rsp;

	integer stim_seed = 32755;
	integer wait_seed = 32755;

	// Memory model and flat reference keyed by byte address
	word_t mem_model [word_t];
	word_t ref_mem [word_t];
	logic mem_dwait = 1'b0;
	word_t mem_load;
	int mem_gen = 0;
	int wait_left = 0;
	int stall;
	// Pair tracking for the two words of a block
	logic pair_half = 1'b0;
	word_t pair_base;
	logic pair_wen;

	dcache dcache_i (
		.CLK(CLK),
		.nRST(nRST),
		.dp_req(dp_req),
		.dp_rsp(dp_rsp),
		.mem_req(mem_req),
		.mem_rsp(mem_rsp)
	);

	bind dcache dcache_assertions dcache_assertions_i (
		.CLK(CLK),
		.nRST(nRST),
		.mem_req(mem_req),
		.mem_rsp(mem_rsp),
		.dp_rsp(dp_rsp)
	);

	initial begin
		CLK = 1'b0;
		forever #(CLK_PERIOD / 2) CLK = ~CLK;
	end

	//////////////////////////////
	// Helpers
	//////////////////////////////

	// Initial memory content
	// Odd multiplier mixes every address bit
	function automatic word_t pattern_word(input word_t addr);
		return (addr * 32'h9E37_79B9) ^ 32'hC0DE_0000;
	endfunction

	function automatic word_t model_word(input word_t addr);
		return mem_model.exists(addr) ? mem_model[addr] : pattern_word(addr);
	endfunction

	function automatic word_t expected_word(input word_t addr);
		return ref_mem.exists(addr) ? ref_mem[addr] : pattern_word(addr);
	endfunction

	task automatic check_value(input string name, input word_t expected, input word_t actual);
		if (expected !== actual) begin
			$display("FAILED %s: expected %h, actual %h", name, expected, actual);
			$display("sim failed");
			$fatal(1, "Mismatch in %s", name);
		end
	endtask

	// Holds one request until hit and lets it complete on the next edge
	task automatic run_access(input logic is_write, input word_t addr, input word_t data,
		input string name);
		word_t got;
		word_t expected;
		dp_req <= '{ren: !is_write, wen: is_write, halt: 1'b0, addr: addr, store: data};
		@(negedge CLK);
		while (!dp_rsp.hit) begin
			@(negedge CLK);
		end
		got = dp_rsp.load;
		expected = expected_word(addr);
		@(posedge CLK);
		if (is_write) begin
			ref_mem[addr] = data;
		end else begin
			check_value(name, expected, got);
		end
	endtask

	//////////////////////////////
	// Memory model
	//////////////////////////////

	// Read data follows the address with no delay
	always @(mem_req or mem_gen) begin
		mem_load = model_word(mem_req.addr);
	end

	assign mem_rsp = {mem_dwait, mem_load};

	// Random 0 to 3 wait cycles per transfer
	always @(posedge CLK) begin
		if (nRST && (mem_req.ren || mem_req.wen)) begin
			if (!mem_dwait) begin
				// Transfer completes on this edge
				check_value("transfer word alignment", 32'h0, word_t'(mem_req.addr[1:0]));
				if (!pair_half) begin
					check_value("transfer pair even word", 32'h0, word_t'(mem_req.addr[2]));
					pair_base = mem_req.addr;
					pair_wen = mem_req.wen;
				end else begin
					check_value("transfer pair odd word", pair_base | 32'h4, mem_req.addr);
					check_value("transfer pair direction", word_t'(pair_wen),
						word_t'(mem_req.wen));
				end
				pair_half = !pair_half;
				if (mem_req.wen) begin
					mem_model[mem_req.addr] = mem_req.store;
					mem_gen <= mem_gen + 1;
				end
				stall = $unsigned($random(wait_seed)) % 4;
				wait_left <= stall;
				mem_dwait <= (stall != 0);
			end else begin
				wait_left <= wait_left - 1;
				mem_dwait <= (wait_left > 1);
			end
		end
	end

	//////////////////////////////
	// Watchdog
	//////////////////////////////

	initial begin
		#(TIMEOUT_CYCLES * CLK_PERIOD);
		$display("Timeout: run not finished after %0d cycles", TIMEOUT_CYCLES);
		$display("sim failed");
		$fatal(1, "Watchdog expired");
	end

	// Any failed property in the bound checker ends the run
	initial begin
		wait (dcache_i.dcache_assertions_i.prop_failed);
		$display("Bound checker assertion failed on the memory bus or flush protocol");
		$display("sim failed");
		$fatal(1, "Assertion failure");
	end

	//////////////////////////////
	// Stimulus
	//////////////////////////////

	initial begin
		logic is_write;
		word_t addr;
		word_t data;
		int tag_sel;
		dp_req = '0;
		nRST = 1'b0;
		repeat (RESET_CYCLES) @(posedge CLK);
		nRST <= 1'b1;
		@(posedge CLK);

		// Cold reads return the initial pattern
		run_access(1'b0, 32'h0000_1040, 32'h0, "cold read even word");
		run_access(1'b0, 32'h0000_3014, 32'h0, "cold read odd word");
		// Store on a resident block
		run_access(1'b1, 32'h0000_1040, 32'hDEAD_BEEF, "store resident");
		run_access(1'b0, 32'h0000_1040, 32'h0, "read after resident store");
		// Store miss allocates first
		run_access(1'b1, 32'h0000_2064, 32'h1234_5678, "store miss");
		run_access(1'b0, 32'h0000_2064, 32'h0, "read after store miss");

		// Two sets and several tags so dirty victims go out and come back
		for (int i = 0; i < NUM_OPS; i++) begin
			tag_sel = $unsigned($random(stim_seed)) % NUM_TAGS;
			addr = {tag_t'(32'h100 + tag_sel * 32'h31),
				(($random(stim_seed) & 1) != 0) ? idx_t'(5) : idx_t'(2),
				blk_off_t'($random(stim_seed) & 1), 2'b00};
			is_write = ($random(stim_seed) & 1) != 0;
			data = $random(stim_seed);
			if (is_write) begin
				run_access(1'b1, addr, data, $sformatf("random store %h", addr));
			end else begin
				run_access(1'b0, addr, 32'h0, $sformatf("random read %h", addr));
			end
		end

		// Flush all dirty blocks
		dp_req <= '{ren: 1'b0, wen: 1'b0, halt: 1'b1, addr: 32'h0, store: 32'h0};
		@(negedge CLK);
		while (!dp_rsp.flushed) begin
			@(negedge CLK);
		end
		repeat (3) @(negedge CLK);
		check_value("flushed held", 32'h1, word_t'(dp_rsp.flushed));
		check_value("transfer pair complete", 32'h0, word_t'(pair_half));

		// Memory now holds every stored word
		foreach (ref_mem[a]) begin
			check_value($sformatf("memory after flush %h", a), ref_mem[a], model_word(a));
		end

		$display("sim passed");
		$finish;
	end

endmodule

`default_nettype wire

// File: tb/dcache_assertions.sv
`timescale 1ns/10ps
`default_nettype none

module dcache_assertions
	import dcache_pkg::*, cache_bus_pkg::*;
(
	input wire logic CLK,
	input wire logic nRST,
	input wire mem_req_t mem_req,
	input wire mem_rsp_t mem_rsp,
	input wire dp_rsp_t dp_rsp
);

	// Raised by any failing property
	logic prop_failed = 1'b0;

	//////////////////////////////
	// Memory bus
	//////////////////////////////

	// One direction per transfer
	no_read_and_write: assert property (
		@(posedge CLK) disable iff (!nRST)
		!(mem_req.ren && mem_req.wen)
	) else begin
		$error("memory read and write requested in the same cycle");
		prop_failed = 1'b1;
	end

	// Stalled request keeps address, data and direction
	stable_during_wait: assert property (
		@(posedge CLK) disable iff (!nRST)
		(mem_req.ren || mem_req.wen) && mem_rsp.dwait |=> $stable(mem_req)
	) else begin
		$error("memory request changed while wait was high");
		prop_failed = 1'b1;
	end

	//////////////////////////////
	// Datapath side
	//////////////////////////////

	// Flush done is sticky until reset
	flushed_held: assert property (
		@(posedge CLK) disable iff (!nRST)
		dp_rsp.flushed |=> dp_rsp.flushed
	) else begin
		$error("flushed dropped after it was raised");
		prop_failed = 1'b1;
	end

	// Hits only come from IDLE and never during a transfer
	no_hit_during_transfer: assert property (
		@(posedge CLK) disable iff (!nRST)
		!(dp_rsp.hit && (mem_req.ren || mem_req.wen))
	) else begin
		$error("hit raised while a memory transfer was active");
		prop_failed = 1'b1;
	end

endmodule

`default_nettype wire

// File: hw/dcache.sv
`timescale 1ns/10ps
`default_nettype none

module dcache
	import dcache_pkg::*, cache_bus_pkg::*;
(
	input wire logic CLK,
	input wire logic nRST,
	input dp_req_t dp_req,
	output dp_rsp_t dp_rsp,
	output mem_req_t mem_req,
	input mem_rsp_t mem_rsp
);

	// Controller to array
	array_cmd_t cmd;
	array_stat_t stat;
	// Write-back read select
	idx_t rd_idx;
	way_t rd_way;
	blk_off_t rd_blk;
	word_t rd_word;
	word_t hit_load;
	logic hit;
	logic flushed;

	//////////////////////////////
	// Storage and lookup
	//////////////////////////////

	// Lookup always follows the datapath address
	dcache_array array_i (
		.CLK(CLK),
		.nRST(nRST),
		.lookup_addr(dp_req.addr),
		.cmd(cmd),
		.rd_idx(rd_idx),
		.rd_way(rd_way),
		.rd_blk(rd_blk),
		.stat(stat),
		.hit_load(hit_load),
		.rd_word(rd_word)
	);

	//////////////////////////////
	// Control
	//////////////////////////////

	dcache_ctrl ctrl_i (
		.CLK(CLK),
		.nRST(nRST),
		.dp_req(dp_req),
		.stat(stat),
		.mem_rsp(mem_rsp),
		.rd_word(rd_word),
		.cmd(cmd),
		.rd_idx(rd_idx),
		.rd_way(rd_way),
		.rd_blk(rd_blk),
		.mem_req(mem_req),
		.hit(hit),
		.flushed(flushed)
	);

	// Datapath response
	assign dp_rsp.hit = hit;
	assign dp_rsp.load = hit_load;
	assign dp_rsp.flushed = flushed;

endmodule

`default_nettype wire

// File: hw/dcache_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module dcache_ctrl
	import dcache_pkg::*, cache_bus_pkg::*;
(
	input wire logic CLK,
	input wire logic nRST,
	input dp_req_t dp_req,
	input array_stat_t stat,
	input mem_rsp_t mem_rsp,
	input word_t rd_word,
	output array_cmd_t cmd,
	output idx_t rd_idx,
	output way_t rd_way,
	output blk_off_t rd_blk,
	output mem_req_t mem_req,
	output logic hit,
	output logic flushed
);

	ctrl_state_t state;
	ctrl_state_t next_state;

	// Request address fields
	tag_t req_tag;
	idx_t req_idx;
	blk_off_t req_blk;
	logic req_valid;
	// Word of the block in flight
	logic word_sel;
	// Transfer completes this edge
	logic xfer_done;
	logic in_flush_wb;

	assign req_tag = dp_req.addr[WORD_W-1 -: TAG_W];
	assign req_idx = dp_req.addr[BYTE_OFF_W+1 +: IDX_W];
	assign req_blk = dp_req.addr[BYTE_OFF_W];
	assign req_valid = dp_req.ren || dp_req.wen;

	// Hits only count while idle
	assign hit = (state == IDLE) && req_valid && stat.hit;
	assign flushed = (state == FLUSHED);

	assign word_sel = (state == WB2) || (state == FD2) || (state == WBD2);
	assign xfer_done = !mem_rsp.dwait;
	assign in_flush_wb = (state == WBD1) || (state == WBD2);

	//////////////////////////////
	// State machine
	//////////////////////////////

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			state <= IDLE;
		end else begin
			state <= next_state;
		end
	end

	always_comb begin
		next_state = state;
		case (state)
			IDLE: begin
				// Halt takes priority over a miss
				if (dp_req.halt) begin
					next_state = DCHK;
				end else if (req_valid && !stat.hit) begin
					next_state = stat.victim_dirty ? WB1 : FD1;
				end
			end
			// Each transfer state holds while memory stalls
			WB1: if (xfer_done) next_state = WB2;
			WB2: if (xfer_done) next_state = FD1;
			FD1: if (xfer_done) next_state = FD2;
			// Back to idle, repeated lookup then hits
			FD2: if (xfer_done) next_state = IDLE;
			DCHK: begin
				next_state = stat.any_dirty ? WBD1 : FLUSHED;
			end
			WBD1: if (xfer_done) next_state = WBD2;
			WBD2: if (xfer_done) next_state = DCHK;
			// Held until reset
			FLUSHED: next_state = FLUSHED;
			default: next_state = IDLE;
		endcase
	end

	//////////////////////////////
	// Memory request
	//////////////////////////////

	always_comb begin
		mem_req.ren = (state == FD1) || (state == FD2);
		mem_req.wen = (state == WB1) || (state == WB2) || in_flush_wb;
		if ((state == WB1) || (state == WB2)) begin
			// Victim block at the requested index
			mem_req.addr = {stat.victim_tag, req_idx, word_sel, {BYTE_OFF_W{1'b0}}};
		end else if (in_flush_wb) begin
			mem_req.addr = {stat.dirty_tag, stat.dirty_idx, word_sel, {BYTE_OFF_W{1'b0}}};
		end else begin
			// Fill address, also the idle default
			mem_req.addr = {req_tag, req_idx, word_sel, {BYTE_OFF_W{1'b0}}};
		end
		mem_req.store = rd_word;
	end

	// Read select for write-back data
	// Flush walks the dirty scan, a miss evicts the LRU way
	assign rd_idx = in_flush_wb ? stat.dirty_idx : req_idx;
	assign rd_way = in_flush_wb ? stat.dirty_way : stat.lru_way;
	assign rd_blk = word_sel;

	//////////////////////////////
	// Array commands
	//////////////////////////////

	always_comb begin
		cmd.op = NONE;
		cmd.idx = req_idx;
		cmd.way = stat.hit_way;
		cmd.blk_off = req_blk;
		cmd.tag = req_tag;
		cmd.data = dp_req.store;
		case (state)
			IDLE: begin
				// Store writes on the hit edge, a load only touches LRU
				if (hit) begin
					cmd.op = dp_req.wen ? STORE : TOUCH;
				end
			end
			FD1, FD2: begin
				// Fill the LRU way one word per transfer
				if (xfer_done) begin
					cmd.op = FILL;
					cmd.way = stat.lru_way;
					cmd.blk_off = word_sel;
					cmd.data = mem_rsp.load;
				end
			end
			WBD2: begin
				// Second word is out, block is clean
				if (xfer_done) begin
					cmd.op = CLEAN;
					cmd.idx = stat.dirty_idx;
					cmd.way = stat.dirty_way;
				end
			end
			default: begin
			end
		endcase
	end

endmodule

`default_nettype wire

// File: hw/dcache_array.sv
`timescale 1ns/10ps
`default_nettype none

module dcache_array
	import dcache_pkg::*, cache_bus_pkg::*;
(
	input wire logic CLK,
	input wire logic nRST,
	input word_t lookup_addr,
	input array_cmd_t cmd,
	input idx_t rd_idx,
	input way_t rd_way,
	input blk_off_t rd_blk,
	output array_stat_t stat,
	output word_t hit_load,
	output word_t rd_word
);

	// Per way state bits, indexed [set][way]
	logic [NUM_SETS-1:0][1:0] valid_q;
	logic [NUM_SETS-1:0][1:0] dirty_q;
	// One bit per set, names the way to replace next
	logic [NUM_SETS-1:0] lru_q;
	tag_t tag_q [NUM_SETS][2];
	word_t data_q [NUM_SETS][2][2];

	// Lookup address fields
	tag_t lk_tag;
	idx_t lk_idx;
	blk_off_t lk_blk;
	logic [1:0] way_hit;

	assign lk_tag = lookup_addr[WORD_W-1 -: TAG_W];
	assign lk_idx = lookup_addr[BYTE_OFF_W+1 +: IDX_W];
	assign lk_blk = lookup_addr[BYTE_OFF_W];

	//////////////////////////////
	// Lookup
	//////////////////////////////

	// Tag compare on both ways of the indexed set
	assign way_hit[0] = valid_q[lk_idx][0] && (tag_q[lk_idx][0] == lk_tag);
	assign way_hit[1] = valid_q[lk_idx][1] && (tag_q[lk_idx][1] == lk_tag);

	// Word of the hitting way, only meaningful with hit
	assign hit_load = data_q[lk_idx][way_hit[1]][lk_blk];

	// Write-back read port
	assign rd_word = data_q[rd_idx][rd_way][rd_blk];

	always_comb begin
		stat.hit = |way_hit;
		// Way 1 only when way 0 misses
		stat.hit_way = way_hit[1];
		stat.lru_way = lru_q[lk_idx];
		// Victim needs write-back only if it holds live dirty data
		stat.victim_dirty = valid_q[lk_idx][lru_q[lk_idx]] && dirty_q[lk_idx][lru_q[lk_idx]];
		stat.victim_tag = tag_q[lk_idx][lru_q[lk_idx]];

		// Dirty scan, walked from the top so the lowest way wins
		stat.any_dirty = 1'b0;
		stat.dirty_idx = '0;
		stat.dirty_way = 1'b0;
		stat.dirty_tag = tag_q[0][0];
		for (int s = NUM_SETS - 1; s >= 0; s--) begin
			for (int w = 1; w >= 0; w--) begin
				if (dirty_q[s][w]) begin
					stat.any_dirty = 1'b1;
					stat.dirty_idx = idx_t'(s);
					stat.dirty_way = way_t'(w);
					stat.dirty_tag = tag_q[s][w];
				end
			end
		end
	end

	//////////////////////////////
	// State bits and LRU
	//////////////////////////////

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			valid_q <= '0;
			dirty_q <= '0;
			// All sets replace way 0 first
			lru_q <= '0;
		end else begin
			case (cmd.op)
				TOUCH: begin
					// Point LRU at the other way
					lru_q[cmd.idx] <= ~cmd.way;
				end
				STORE: begin
					dirty_q[cmd.idx][cmd.way] <= 1'b1;
					lru_q[cmd.idx] <= ~cmd.way;
				end
				FILL: begin
					// Fresh copy from memory is clean
					valid_q[cmd.idx][cmd.way] <= 1'b1;
					dirty_q[cmd.idx][cmd.way] <= 1'b0;
				end
				CLEAN: begin
					dirty_q[cmd.idx][cmd.way] <= 1'b0;
				end
				default: begin
				end
			endcase
		end
	end

	//////////////////////////////
	// Tags and data
	//////////////////////////////

	always_ff @(posedge CLK) begin
		// Store and fill share the word write
		if ((cmd.op == STORE) || (cmd.op == FILL)) begin
			data_q[cmd.idx][cmd.way][cmd.blk_off] <= cmd.data;
		end
		// Tag lands with the last word of the fill
		if ((cmd.op == FILL) && cmd.blk_off) begin
			tag_q[cmd.idx][cmd.way] <= cmd.tag;
		end
	end

endmodule

`default_nettype wire

// File: hw/cache_bus_pkg.sv
`default_nettype none

package cache_bus_pkg;

	import dcache_pkg::*;

	//////////////////////////////
	// External ports
	//////////////////////////////

	// Datapath side, held until hit
	typedef struct packed {
		logic ren;
		logic wen;
		logic halt;
		word_t addr;
		word_t store;
	} dp_req_t;

	typedef struct packed {
		logic hit;
		word_t load;
		logic flushed;
	} dp_rsp_t;

	// Memory side, one word per transfer
	typedef struct packed {
		logic ren;
		logic wen;
		word_t addr;
		word_t store;
	} mem_req_t;

	// Memory stall, transfer completes when low
	typedef struct packed {
		logic dwait;
		word_t load;
	} mem_rsp_t;

	//////////////////////////////
	// Controller to array
	//////////////////////////////

	// Array write operations
	typedef enum logic [2:0] {
		NONE,
		TOUCH,
		STORE,
		FILL,
		CLEAN
	} array_op_t;

	typedef struct packed {
		array_op_t op;
		idx_t idx;
		way_t way;
		blk_off_t blk_off;
		tag_t tag;
		word_t data;
	} array_cmd_t;

	// Lookup result plus first dirty block
	typedef struct packed {
		logic hit;
		way_t hit_way;
		way_t lru_way;
		logic victim_dirty;
		tag_t victim_tag;
		logic any_dirty;
		idx_t dirty_idx;
		way_t dirty_way;
		tag_t dirty_tag;
	} array_stat_t;

endpackage

`default_nettype wire

// File: hw/dcache_pkg.sv
`default_nettype none

package dcache_pkg;

	//////////////////////////////
	// Cache geometry
	//////////////////////////////

	// Word size in bits
	localparam int WORD_W = 32;
	// Two ways per set, one LRU bit each
	localparam int NUM_SETS = 8;
	localparam int IDX_W = 3;
	localparam int BYTE_OFF_W = 2;
	// Address is tag | index | block offset | byte offset
	localparam int TAG_W = WORD_W - IDX_W - 1 - BYTE_OFF_W;

	//////////////////////////////
	// Field types
	//////////////////////////////

	typedef logic [WORD_W-1:0] word_t;
	typedef logic [TAG_W-1:0] tag_t;
	typedef logic [IDX_W-1:0] idx_t;
	// Way 0 or way 1
	typedef logic way_t;
	// Word 0 or word 1 of a block
	typedef logic blk_off_t;

	// Controller states
	// WB* write back a dirty victim, FD* fetch the block
	// DCHK and WBD* walk the dirty blocks on halt
	typedef enum logic [3:0] {
		IDLE,
		WB1,
		WB2,
		FD1,
		FD2,
		DCHK,
		WBD1,
		WBD2,
		FLUSHED
	} ctrl_state_t;

endpackage

`default_nettype wire
